// ==== src/boomPkg.sv ====
`default_nettype none

package boomPkg;

  // coordinate widths for the scan position
  localparam int xWidth = 9;
  localparam int yWidth = 8;

  // visible area of the raster
  localparam logic [xWidth-1:0] hActive = 9'd320;
  localparam logic [yWidth-1:0] vActive = 8'd240;

  // full scan including the blanking band
  localparam logic [xWidth-1:0] hTotal = 9'd336;
  localparam logic [yWidth-1:0] vTotal = 8'd248;

  // top left corner of the word on screen
  localparam int startX = 82;
  localparam int startY = 96;

  // horizontal bars, offsets from the word origin
  localparam int numHorBars = 8;
  localparam logic [xWidth-1:0] horX [numHorBars] = '{
    9'd4, 9'd27, 9'd60, 9'd60, 9'd93, 9'd93, 9'd126, 9'd126
  };
  localparam logic [yWidth-1:0] horY [numHorBars] = '{
    8'd42, 8'd42, 8'd0, 8'd42, 8'd0, 8'd42, 8'd0, 8'd42
  };
  localparam int horLen = 20;

  // vertical bars, two stacked per letter side
  localparam int numVerBars = 16;
  localparam logic [xWidth-1:0] verX [numVerBars] = '{
    9'd0, 9'd0, 9'd23, 9'd23, 9'd46, 9'd46, 9'd56, 9'd56,
    9'd79, 9'd79, 9'd89, 9'd89, 9'd112, 9'd112, 9'd122, 9'd122
  };
  localparam logic [yWidth-1:0] verY [numVerBars] = '{
    8'd3, 8'd24, 8'd3, 8'd24, 8'd3, 8'd24, 8'd3, 8'd24,
    8'd3, 8'd24, 8'd3, 8'd24, 8'd3, 8'd24, 8'd3, 8'd24
  };
  localparam int verLen = 20;

  // extra short bars closing the bowls of the B
  localparam int topBX = 137;
  localparam int topBY = 24;
  localparam int topBLen = 17;
  localparam int midBX = 126;
  localparam int midBY = 21;
  localparam int midBLen = 12;
  localparam int botBX = 137;
  localparam int botBY = 6;
  localparam int botBLen = 17;

  // 4 bits per channel, r g b
  localparam int rgbWidth = 12;
  localparam logic [rgbWidth-1:0] bgColor = 12'h004;
  localparam logic [rgbWidth-1:0] fgColor = 12'hFA0;
  // odd frames in flash mode
  localparam logic [rgbWidth-1:0] altColor = 12'hF00;

endpackage

`default_nettype wire

// ==== src/pixelBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pixelBus;

  // current scan position
  logic [boomPkg::xWidth-1:0] x;
  logic [boomPkg::yWidth-1:0] y;
  // position lies inside the visible area
  logic active;
  // position is (0,0)
  logic frameStart;
  // pixel strobe, pipeline stages advance on it
  logic step;

  modport source (output x, output y, output active, output frameStart, output step);

  modport sink (input x, input y, input active, input frameStart, input step);

endinterface

`default_nettype wire

// ==== src/scanCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module scanCounter (
  input logic clk,
  input logic rstN,
  input logic pixelEn,
  pixelBus.source bus
);

  logic [boomPkg::xWidth-1:0] hCount;
  logic [boomPkg::yWidth-1:0] vCount;
  logic hLast;
  logic vLast;

  // last column and last line of the full scan
  assign hLast = (hCount == boomPkg::hTotal - 1'b1);
  assign vLast = (vCount == boomPkg::vTotal - 1'b1);

  // x runs every strobe, y only when x wraps
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hCount <= '0;
      vCount <= '0;
    end else if (pixelEn) begin
      if (hLast) begin
        hCount <= '0;
        if (vLast) begin
          vCount <= '0;
        end else begin
          vCount <= vCount + 1'b1;
        end
      end else begin
        hCount <= hCount + 1'b1;
      end
    end
  end

  assign bus.x = hCount;
  assign bus.y = vCount;

  // visible window is the top left corner of the scan
  assign bus.active = (hCount < boomPkg::hActive) && (vCount < boomPkg::vActive);

  // one position per frame
  assign bus.frameStart = (hCount == '0) && (vCount == '0);

  // strobe travels with the position
  assign bus.step = pixelEn;

endmodule

`default_nettype wire

// ==== src/roundBar.sv ====
`timescale 1ns/1ps
`default_nettype none

module roundBar #(
  parameter int originX = 0,
  parameter int originY = 0,
  parameter int barLen = 20,
  parameter bit vertical = 1'b0
) (
  input logic [boomPkg::xWidth-1:0] x,
  input logic [boomPkg::yWidth-1:0] y,
  output logic hit
);

  // position along the bar and across its 5 pixel width
  logic [boomPkg::xWidth-1:0] alongPos;
  logic [boomPkg::xWidth-1:0] crossPos;
  int alongOff;
  int crossOff;
  logic centreRow;
  logic innerRow;
  logic tipRow;

  // a vertical bar is a horizontal one with x and y swapped
  always_comb begin
    if (vertical) begin
      alongPos = boomPkg::xWidth'(y);
      crossPos = x;
    end else begin
      alongPos = x;
      crossPos = boomPkg::xWidth'(y);
    end
  end

  // signed offsets, negative when left of or above the origin
  assign alongOff = int'(alongPos) - (vertical ? originY : originX);
  assign crossOff = int'(crossPos) - (vertical ? originX : originY);

  // middle row spans the full length
  assign centreRow = (crossOff == 2) && (alongOff >= 0) && (alongOff <= barLen - 1);

  // rows next to it lose one pixel at each end
  assign innerRow = ((crossOff == 1) || (crossOff == 3))
                    && (alongOff >= 1) && (alongOff <= barLen - 2);

  // outer rows lose two, which rounds the ends
  assign tipRow = ((crossOff == 0) || (crossOff == 4))
                  && (alongOff >= 2) && (alongOff <= barLen - 3);

  assign hit = centreRow || innerRow || tipRow;

endmodule

`default_nettype wire

// ==== src/boomGlyph.sv ====
`timescale 1ns/1ps
`default_nettype none

module boomGlyph (
  input logic clk,
  input logic rstN,
  input logic show,
  pixelBus.sink bus,
  output logic wordPixel,
  output logic activeD,
  output logic frameStartD
);

  logic [boomPkg::numHorBars-1:0] horHit;
  logic [boomPkg::numVerBars-1:0] verHit;
  // top, middle and bottom extra of the B
  logic [2:0] bHit;
  logic wordHit;

  // horizontal strokes of B, O, O, M
  for (genvar i = 0; i < boomPkg::numHorBars; i++) begin : genHor
    roundBar #(
      .originX (boomPkg::startX + boomPkg::horX[i]),
      .originY (boomPkg::startY + boomPkg::horY[i]),
      .barLen  (boomPkg::horLen),
      .vertical(1'b0)
    ) u_horBar (
      .x  (bus.x),
      .y  (bus.y),
      .hit(horHit[i])
    );
  end

  // letter sides, upper and lower half each
  for (genvar j = 0; j < boomPkg::numVerBars; j++) begin : genVer
    roundBar #(
      .originX (boomPkg::startX + boomPkg::verX[j]),
      .originY (boomPkg::startY + boomPkg::verY[j]),
      .barLen  (boomPkg::verLen),
      .vertical(1'b1)
    ) u_verBar (
      .x  (bus.x),
      .y  (bus.y),
      .hit(verHit[j])
    );
  end

  roundBar #(
    .originX (boomPkg::startX + boomPkg::topBX),
    .originY (boomPkg::startY + boomPkg::topBY),
    .barLen  (boomPkg::topBLen),
    .vertical(1'b1)
  ) u_topB (.x(bus.x), .y(bus.y), .hit(bHit[0]));

  roundBar #(
    .originX (boomPkg::startX + boomPkg::midBX),
    .originY (boomPkg::startY + boomPkg::midBY),
    .barLen  (boomPkg::midBLen),
    .vertical(1'b0)
  ) u_midB (.x(bus.x), .y(bus.y), .hit(bHit[1]));

  roundBar #(
    .originX (boomPkg::startX + boomPkg::botBX),
    .originY (boomPkg::startY + boomPkg::botBY),
    .barLen  (boomPkg::botBLen),
    .vertical(1'b1)
  ) u_botB (.x(bus.x), .y(bus.y), .hit(bHit[2]));

  // any bar makes the pixel part of the word
  assign wordHit = (|horHit) || (|verHit) || (|bHit);

  // first pipeline stage, flags follow the pixel
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wordPixel <= 1'b0;
      activeD <= 1'b0;
      frameStartD <= 1'b0;
    end else if (bus.step) begin
      wordPixel <= show && wordHit;
      activeD <= bus.active;
      frameStartD <= bus.frameStart;
    end
  end

endmodule

`default_nettype wire

// ==== src/pixelColor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixelColor (
  input logic clk,
  input logic rstN,
  input logic step,
  input logic flash,
  input logic wordPixel,
  input logic activeD,
  input logic frameStartD,
  output logic [11:0] rgb,
  output logic activeOut,
  output logic frameStartOut
);

  logic [7:0] frameCount;
  // frame number that the current pixel belongs to
  logic [7:0] frameNext;
  logic [boomPkg::rgbWidth-1:0] colorNext;

  // the first pixel of a frame already sees the new number
  assign frameNext = frameStartD ? frameCount + 1'b1 : frameCount;

  always_comb begin
    if (!activeD) begin
      // blanking band is black
      colorNext = '0;
    end else if (wordPixel) begin
      // odd frames swap to the alternate colour when flashing
      colorNext = (flash && frameNext[0]) ? boomPkg::altColor : boomPkg::fgColor;
    end else begin
      colorNext = boomPkg::bgColor;
    end
  end

  // frame counter moves only with the stream
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      frameCount <= '0;
    end else if (step) begin
      frameCount <= frameNext;
    end
  end

  // second pipeline stage
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rgb <= '0;
      activeOut <= 1'b0;
      frameStartOut <= 1'b0;
    end else if (step) begin
      rgb <= colorNext;
      activeOut <= activeD;
      frameStartOut <= frameStartD;
    end
  end

endmodule

`default_nettype wire

// ==== src/boomDisplay.sv ====
`timescale 1ns/1ps
`default_nettype none

module boomDisplay (
  input logic clk,
  input logic rstN,
  input logic pixelEn,
  input logic show,
  input logic flash,
  output logic [11:0] rgb,
  output logic activeOut,
  output logic frameStartOut
);

  // glyph stage to colour stage
  logic wordPixel;
  logic activeD;
  logic frameStartD;

  pixelBus pixBus ();

  // scan position and its flags
  scanCounter u_scanCounter (
    .clk    (clk),
    .rstN   (rstN),
    .pixelEn(pixelEn),
    .bus    (pixBus.source)
  );

  // word shape, one strobe behind the counter
  boomGlyph u_boomGlyph (
    .clk        (clk),
    .rstN       (rstN),
    .show       (show),
    .bus        (pixBus.sink),
    .wordPixel  (wordPixel),
    .activeD    (activeD),
    .frameStartD(frameStartD)
  );

  // colour and blanking, two strobes behind the counter
  pixelColor u_pixelColor (
    .clk          (clk),
    .rstN         (rstN),
    .step         (pixBus.step),
    .flash        (flash),
    .wordPixel    (wordPixel),
    .activeD      (activeD),
    .frameStartD  (frameStartD),
    .rgb          (rgb),
    .activeOut    (activeOut),
    .frameStartOut(frameStartOut)
  );

endmodule

`default_nettype wire

// ==== sim/boomDisplay_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module boomDisplayChk (
  input logic clk,
  input logic rstN,
  input logic pixelEn,
  input logic [11:0] rgb,
  input logic activeOut,
  input logic frameStartOut
);

  // blanking band is always black
  blankBlack: assert property (@(posedge clk) disable iff (!rstN) !activeOut |-> rgb == '0)
    else $error("rgb is not black while activeOut is low");

  // a strobe always moves the output off the first pixel of the frame
  singleStart: assert property (@(posedge clk) disable iff (!rstN)
    frameStartOut && pixelEn |=> !frameStartOut)
    else $error("frameStartOut stayed high over two strobes");

  // pixel (0,0) lies in the visible corner
  startVisible: assert property (@(posedge clk) disable iff (!rstN)
    frameStartOut |-> activeOut)
    else $error("frameStartOut high outside the visible area");

endmodule

bind boomDisplay boomDisplayChk u_boomDisplayChk (.*);

`default_nettype wire

// ==== sim/boomDisplayTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module boomDisplayTb;

  // frame, x, y, show, flash, expected rgb
  typedef struct packed {
    logic [3:0] frame;
    logic [8:0] x;
    logic [7:0] y;
    logic show;
    logic flash;
    logic [11:0] rgb;
  } probeRow;

  localparam int nRows = 16;
  localparam int waitLimit = 300000;

  // rows of one frame in scan order, sharing show and flash
  localparam probeRow probes [nRows] = '{
    // B extras, then the rounded corner of the B base
    {4'd1, 9'd221, 8'd102, 1'b1, 1'b0, 12'hFA0},
    {4'd1, 9'd221, 8'd120, 1'b1, 1'b0, 12'hFA0},
    {4'd1, 9'd86, 8'd138, 1'b1, 1'b0, 12'h004},
    {4'd1, 9'd86, 8'd139, 1'b1, 1'b0, 12'h004},
    {4'd1, 9'd87, 8'd139, 1'b1, 1'b0, 12'hFA0},
    {4'd1, 9'd86, 8'd140, 1'b1, 1'b0, 12'hFA0},
    // even frame keeps fgColor while flashing
    {4'd2, 9'd219, 8'd119, 1'b1, 1'b1, 12'hFA0},
    {4'd2, 9'd220, 8'd119, 1'b1, 1'b1, 12'h004},
    {4'd2, 9'd221, 8'd136, 1'b1, 1'b1, 12'hFA0},
    {4'd2, 9'd221, 8'd137, 1'b1, 1'b1, 12'h004},
    // odd frame flashes, O top bar centre
    {4'd3, 9'd150, 8'd98, 1'b1, 1'b1, 12'hF00},
    // word hidden, blanking black
    {4'd4, 9'd320, 8'd10, 1'b0, 1'b1, 12'h000},
    {4'd4, 9'd150, 8'd98, 1'b0, 1'b1, 12'h004},
    {4'd4, 9'd319, 8'd239, 1'b0, 1'b1, 12'h004},
    {4'd4, 9'd5, 8'd245, 1'b0, 1'b1, 12'h000},
    {4'd5, 9'd86, 8'd140, 1'b1, 1'b0, 12'hFA0}
  };

  logic clk;
  logic rstN;
  logic pixelEn;
  logic show;
  logic flash;
  logic [11:0] rgb;
  logic activeOut;
  logic frameStartOut;

  // position of the output stream, locked on frameStartOut
  int frameNum = 0;
  int posX = 0;
  int posY = 0;
  int strobes = 0;
  int waited;
  bit synced = 1'b0;
  // strobe driven on the last falling edge
  bit lastEn = 1'b0;

  boomDisplay u_boomDisplay (
    .clk          (clk),
    .rstN         (rstN),
    .pixelEn      (pixelEn),
    .show         (show),
    .flash        (flash),
    .rgb          (rgb),
    .activeOut    (activeOut),
    .frameStartOut(frameStartOut)
  );

  // a row at distance d from the bar centre loses d pixels at each end
  function automatic bit onBar(int px, int py, int ox, int oy, int len, bit vert);
    int along;
    int across;
    int d;
    along = vert ? py - oy : px - ox;
    across = vert ? px - ox : py - oy;
    d = (across > 2) ? across - 2 : 2 - across;
    return (across >= 0) && (across <= 4) && (along >= d) && (along <= len - 1 - d);
  endfunction

  // reference colour of one pixel
  function automatic logic [11:0] expectRgb(int px, int py, bit sh, bit fl, int frame);
    bit hit;
    int ox;
    int oy;
    hit = 1'b0;
    ox = boomPkg::startX;
    oy = boomPkg::startY;
    if (px >= boomPkg::hActive || py >= boomPkg::vActive) begin
      return 12'h000;
    end
    for (int i = 0; i < boomPkg::numHorBars; i++) begin
      hit |= onBar(px, py, ox + boomPkg::horX[i], oy + boomPkg::horY[i], boomPkg::horLen, 0);
    end
    for (int i = 0; i < boomPkg::numVerBars; i++) begin
      hit |= onBar(px, py, ox + boomPkg::verX[i], oy + boomPkg::verY[i], boomPkg::verLen, 1);
    end
    // the three short bars of the B
    hit |= onBar(px, py, ox + boomPkg::topBX, oy + boomPkg::topBY, boomPkg::topBLen, 1);
    hit |= onBar(px, py, ox + boomPkg::midBX, oy + boomPkg::midBY, boomPkg::midBLen, 0);
    hit |= onBar(px, py, ox + boomPkg::botBX, oy + boomPkg::botBY, boomPkg::botBLen, 1);
    if (!(sh && hit)) begin
      return boomPkg::bgColor;
    end
    return (fl && frame[0]) ? boomPkg::altColor : boomPkg::fgColor;
  endfunction

  task automatic reportFail(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  // sample what the last rising edge produced, then drive the next strobe
  task automatic clockPixel();
    int nx;
    int ny;
    logic [11:0] expRgb;
    @(negedge clk);
    if (lastEn) begin
      strobes++;
      nx = (posX == boomPkg::hTotal - 1) ? 0 : posX + 1;
      ny = (nx != 0) ? posY : ((posY == boomPkg::vTotal - 1) ? 0 : posY + 1);
      // (0,0) is shown at reset, so its output comes on the second strobe
      if (!synced) begin
        assert (frameStartOut ? strobes == 2 : (rgb == '0 && !activeOut))
          else reportFail("first frame start or reset values of the outputs are wrong");
      end else begin
        assert (frameStartOut == (nx == 0 && ny == 0))
          else reportFail($sformatf("[ERROR] %0t ns frameStartOut=%b after x=%0d y=%0d",
                                    $time, frameStartOut, posX, posY));
      end
      if (frameStartOut) begin
        synced = 1'b1;
        frameNum++;
        // word pixels lie far from row 0, so switching here is safe
        for (int r = 0; r < nRows; r++) begin
          if (probes[r].frame == frameNum) begin
            show = probes[r].show;
            flash = probes[r].flash;
          end
        end
      end
      posX = frameStartOut ? 0 : nx;
      posY = frameStartOut ? 0 : ny;
      expRgb = expectRgb(posX, posY, show, flash, frameNum);
      if (synced) begin
        assert (rgb == expRgb
                && activeOut == (posX < boomPkg::hActive && posY < boomPkg::vActive))
          else reportFail($sformatf("[ERROR] %0t ns x=%0d y=%0d expected %03h actual %03h",
                                    $time, posX, posY, expRgb, rgb));
      end
    end
    // gated strobe in the second half of the run
    lastEn = (frameNum >= 3) ? (($urandom % 4) != 0) : 1'b1;
    pixelEn = lastEn;
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    void'($urandom(32'h218a));
    rstN = 1'b0;
    pixelEn = 1'b0;
    show = probes[0].show;
    flash = probes[0].flash;
    repeat (3) begin
      @(negedge clk);
      assert (rgb == '0 && !activeOut && !frameStartOut)
        else reportFail("outputs are not cleared during reset");
    end
    rstN = 1'b1;
    lastEn = 1'b1;
    pixelEn = 1'b1;
    for (int r = 0; r < nRows; r++) begin
      waited = 0;
      while (!(synced && frameNum == probes[r].frame
               && posX == probes[r].x && posY == probes[r].y)) begin
        clockPixel();
        waited++;
        if (waited > waitLimit) begin
          reportFail($sformatf("timed out waiting for pixel x=%0d y=%0d of frame %0d",
                               probes[r].x, probes[r].y, probes[r].frame));
        end
      end
      assert (rgb == probes[r].rgb)
        else reportFail($sformatf("[ERROR] %0t ns probe x=%0d y=%0d expected %03h actual %03h",
                                  $time, posX, posY, probes[r].rgb, rgb));
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
src/boomPkg.sv
src/pixelBus.sv
src/scanCounter.sv
src/roundBar.sv
src/boomGlyph.sv
src/pixelColor.sv
src/boomDisplay.sv
sim/boomDisplay_chk.sv
sim/boomDisplayTb.sv
